//--- sim.f
hdl/apple1_map_pkg.sv
hdl/pia_pkg.sv
hdl/mem_bus_if.sv
hdl/bus_decoder.sv
hdl/ram.sv
hdl/pia_terminal.sv
hdl/apple1_core.sv
test/apple1_core_assert.sv
test/tb_apple1_core.sv

//--- Makefile
# verilator build and run of the apple-1 bus subsystem testbench

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module tb_apple1_core -f sim.f
	./obj_dir/Vtb_apple1_core

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- test/tb_apple1_core.sv
// testbench for the apple-1 bus subsystem, table driven against a reference model
`timescale 1ns/1ps

module tb_apple1_core import apple1_map_pkg::*; import pia_pkg::*; ();

    logic    clk25 = 1'b0;
    logic    rst_n, req_valid, req_ready, rsp_valid, key_valid, key_ready;
    logic    dsp_valid, dsp_ready;
    bus_op_e req_op;
    addr_t   req_addr;
    data_t   req_wdata, rsp_rdata, key_data, dsp_data;

    apple1_core i_dut (.*);

    always #2 clk25 = ~clk25;                   // 4 ns period

    ////////////////////
    // stimulus table

    typedef struct packed {
        logic    req;                           // bus request this cycle
        bus_op_e op;
        addr_t   addr;
        data_t   wdata;
        logic    key_en;                        // key offered
        data_t   key;
        logic    dsp_rdy;
        data_t   exp_rd;                        // read value, checked next cycle
        logic    exp_kr;                        // key_ready before this edge
        logic    exp_dv;                        // dsp_valid before this edge
        data_t   exp_dsp;                       // character on dsp_data
    } step_t;

    step_t steps[$];
    string names[$];
    data_t ram_mdl [8192];                      // reference ram, 0x0000..0x1fff
    data_t m_kbd, m_dsp;
    logic  m_pend = 1'b0, m_busy = 1'b0;        // terminal flags after reset
    logic  k_en, d_rdy;                         // stream inputs for the next steps
    data_t k_byte;
    int    cycles = 0, limit = 1000;

    // one table row, expected values from the model state before the edge
    task automatic add_step(input string name, input logic req, input bus_op_e op,
                            input addr_t addr, input data_t wdata);
        step_t s;
        logic  wr;
        logic  ram_hit;
        wr      = req && op == BUS_WRITE;
        ram_hit = addr < 16'h2000;
        s = '{req: req, op: op, addr: addr, wdata: wdata, key_en: k_en, key: k_byte,
              dsp_rdy: d_rdy, exp_rd: UNMAPPED_DATA, exp_kr: !m_pend, exp_dv: m_busy,
              exp_dsp: m_dsp};
        if (ram_hit) begin
            s.exp_rd = ram_mdl[addr[12:0]];
        end else if (addr >= 16'hD010 && addr <= 16'hD013) begin
            s.exp_rd = 8'h00;                   // DSPCR and spare bits
            case (pia_reg_e'(addr[1:0]))
                KBD:   s.exp_rd = {1'b1, m_kbd[6:0]};
                KBDCR: s.exp_rd[7] = m_pend;
                DSP:   s.exp_rd[7] = m_busy;
                DSPCR: s.exp_rd = 8'h00;
            endcase
        end
        // model state after the edge
        if (k_en && !m_pend) begin
            m_pend = 1'b1;
            m_kbd  = k_byte;
        end else if (req && !wr && addr == 16'hD010) begin
            m_pend = 1'b0;                      // KBD read acknowledges
        end
        if (wr && ram_hit) ram_mdl[addr[12:0]] = wdata;
        if (!m_busy && wr && addr == 16'hD012) begin
            m_busy = 1'b1;
            m_dsp  = wdata;
        end else if (m_busy && d_rdy) begin
            m_busy = 1'b0;                      // character delivered
        end
        steps.push_back(s);
        names.push_back(name);
    endtask

    ////////////////////
    // checks

    task automatic abort_run(input string why);
        $display("*** FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic check_rdata(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("error %s: expected %02h, got %02h", name, exp, act);
            abort_run("read data mismatch");
        end
    endtask

    task automatic check_dsp(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("error %s: expected display %02h, got %02h", name, exp, act);
            abort_run("display character mismatch");
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("error %s %s: expected %b, got %b", name, what, exp, act);
            abort_run("handshake flag mismatch");
        end
    endtask

    always @(posedge clk25) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("*** FAILED ***");
            $fatal(1, "timeout after %0d cycles, the run did not reach its end", cycles);
        end
    end

    ////////////////////
    // main sequence

    initial begin
        addr_t ram_a [8];
        step_t s;
        logic  rsp_due;
        data_t rsp_exp;
        string rsp_name;
        void'($urandom(32'he81d_e081));
        k_en   = 1'b0;
        k_byte = 8'h00;
        d_rdy  = 1'b0;
        foreach (ram_a[i]) ram_a[i] = addr_t'($urandom_range(16'h1FFF));
        foreach (ram_a[i]) begin
            add_step($sformatf("ram write %0d", i), 1'b1, BUS_WRITE, ram_a[i],
                     data_t'($urandom));
        end
        foreach (ram_a[i]) begin
            add_step($sformatf("ram read %0d", i), 1'b1, BUS_READ, ram_a[i], 8'h00);
        end
        add_step("ram write 0000", 1'b1, BUS_WRITE, 16'h0000, 8'h3C);
        add_step("unmapped write 4000", 1'b1, BUS_WRITE, 16'h4000, 8'h5A);
        add_step("unmapped write d014", 1'b1, BUS_WRITE, 16'hD014, 8'hA5);
        add_step("unmapped read 4000", 1'b1, BUS_READ, 16'h4000, 8'h00);
        add_step("unmapped read d014", 1'b1, BUS_READ, 16'hD014, 8'h00);
        add_step("unmapped read 2000", 1'b1, BUS_READ, 16'h2000, 8'h00);
        add_step("ram 0000 unchanged", 1'b1, BUS_READ, 16'h0000, 8'h00);
        add_step("kbdcr idle", 1'b1, BUS_READ, 16'hD011, 8'h00);
        k_en   = 1'b1;
        k_byte = 8'h41;
        add_step("key a offered", 1'b0, BUS_READ, 16'h0000, 8'h00);
        k_byte = 8'h42;                         // held while a is pending
        add_step("kbdcr pending", 1'b1, BUS_READ, 16'hD011, 8'h00);
        add_step("kbd read a", 1'b1, BUS_READ, 16'hD010, 8'h00);
        add_step("key b taken", 1'b0, BUS_READ, 16'h0000, 8'h00);
        k_en   = 1'b0;
        add_step("kbd read b", 1'b1, BUS_READ, 16'hD010, 8'h00);
        add_step("kbdcr cleared", 1'b1, BUS_READ, 16'hD011, 8'h00);
        add_step("dsp write", 1'b1, BUS_WRITE, 16'hD012, 8'h8D);
        add_step("dsp busy", 1'b1, BUS_READ, 16'hD012, 8'h00);
        add_step("dsp write dropped", 1'b1, BUS_WRITE, 16'hD012, 8'hC1);
        add_step("dsp still busy", 1'b1, BUS_READ, 16'hD012, 8'h00);
        d_rdy = 1'b1;
        add_step("dsp release", 1'b0, BUS_READ, 16'h0000, 8'h00);
        add_step("dsp idle", 1'b1, BUS_READ, 16'hD012, 8'h00);
        add_step("dspcr read", 1'b1, BUS_READ, 16'hD013, 8'h00);
        add_step("drain", 1'b0, BUS_READ, 16'h0000, 8'h00);
        limit = 4 * steps.size() + 200;

        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = BUS_READ;
        req_addr  = '0;
        req_wdata = '0;
        key_valid = 1'b0;
        key_data  = '0;
        dsp_ready = 1'b0;
        rsp_due   = 1'b0;
        rsp_exp   = '0;
        rsp_name  = "";
        repeat (5) @(posedge clk25);
        @(negedge clk25);
        rst_n = 1'b1;
        check_flag("reset", "rsp_valid", 1'b0, rsp_valid);
        check_flag("reset", "dsp_valid", 1'b0, dsp_valid);
        check_flag("reset", "key_ready", 1'b1, key_ready);
        while (!req_ready) @(negedge clk25);

        foreach (steps[i]) begin
            s = steps[i];
            check_flag(names[i], "rsp_valid", rsp_due, rsp_valid);  // previous read
            if (rsp_due) check_rdata(rsp_name, rsp_exp, rsp_rdata);
            check_flag(names[i], "key_ready", s.exp_kr, key_ready);
            check_flag(names[i], "dsp_valid", s.exp_dv, dsp_valid);
            req_valid = s.req;
            req_op    = s.op;
            req_addr  = s.addr;
            req_wdata = s.wdata;
            key_valid = s.key_en;
            key_data  = s.key;
            dsp_ready = s.dsp_rdy;
            if (dsp_valid && s.dsp_rdy) begin
                check_dsp(names[i], s.exp_dsp, dsp_data);   // taken on the coming edge
            end
            rsp_due  = s.req && s.op == BUS_READ;
            rsp_exp  = s.exp_rd;
            rsp_name = names[i];
            @(negedge clk25);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- test/apple1_core_assert.sv
// concurrent checks on the cpu request/response and display stream handshakes
`timescale 1ns/1ps

module apple1_core_assert import apple1_map_pkg::*; (
    input logic    clk25,
    input logic    rst_n,
    input logic    req_valid,
    input logic    req_ready,
    input bus_op_e req_op,
    input logic    rsp_valid,
    input logic    dsp_valid,
    input logic    dsp_ready,
    input data_t   dsp_data
);

    ////////////////////
    // request and response

    // accepted read -> response on the next edge
    assert property (@(posedge clk25) disable iff (!rst_n)
        (req_valid && req_ready && req_op == BUS_READ) |=> rsp_valid)
        else $error("no rsp_valid one cycle after an accepted read");

    // and no response without one
    assert property (@(posedge clk25) disable iff (!rst_n)
        rsp_valid |-> $past(req_valid && req_ready && req_op == BUS_READ))
        else $error("rsp_valid without an accepted read the cycle before");

    assert property (@(posedge clk25) disable iff (!rst_n)
        $past(rst_n) |-> req_ready)
        else $error("req_ready low after reset");

    ////////////////////
    // display stream

    assert property (@(posedge clk25) disable iff (!rst_n)
        (dsp_valid && !dsp_ready) |=> (dsp_valid && $stable(dsp_data)))
        else $error("display character dropped or changed while stalled");

endmodule

bind apple1_core apple1_core_assert i_assert (.*);

//--- hdl/apple1_core.sv
// apple-1 bus subsystem top with the cpu port, ram and terminal adapter
`timescale 1ns/1ps

module apple1_core import apple1_map_pkg::*; #(
    parameter int RAM_ADDR_BITS = 13            // 8 KB at 0x0000
) (
    input  logic    clk25,                      // 25 MHz master clock
    input  logic    rst_n,                      // async, active low

    // cpu-side request
    input  logic    req_valid,
    output logic    req_ready,
    input  bus_op_e req_op,
    input  addr_t   req_addr,
    input  data_t   req_wdata,

    // cpu-side response, one cycle after a read
    output logic    rsp_valid,
    output data_t   rsp_rdata,

    // keyboard stream
    input  logic    key_valid,
    output logic    key_ready,
    input  data_t   key_data,

    // display stream
    output logic    dsp_valid,
    input  logic    dsp_ready,
    output data_t   dsp_data
);

    ////////////////////
    // slave ports

    mem_bus_if ram_bus ();
    mem_bus_if pia_bus ();

    ////////////////////
    // address decoding

    bus_decoder #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) i_decoder (
        .clk25     (clk25),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .ram_bus   (ram_bus),
        .pia_bus   (pia_bus)
    );

    ////////////////////
    // ram and peripherals

    ram #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) i_ram (
        .clk25 (clk25),
        .bus   (ram_bus)
    );

    pia_terminal i_pia (
        .clk25     (clk25),
        .rst_n     (rst_n),
        .bus       (pia_bus),
        .key_valid (key_valid),
        .key_ready (key_ready),
        .key_data  (key_data),
        .dsp_valid (dsp_valid),
        .dsp_ready (dsp_ready),
        .dsp_data  (dsp_data)
    );

endmodule

//--- hdl/pia_terminal.sv
// keyboard and display registers of the terminal adapter with their byte streams
`timescale 1ns/1ps

module pia_terminal import apple1_map_pkg::*; import pia_pkg::*; (
    input  logic  clk25,                        // 25 MHz master clock
    input  logic  rst_n,

    mem_bus_if.slave bus,                       // decoded 0xD010 window

    // keyboard stream in
    input  logic  key_valid,
    output logic  key_ready,
    input  data_t key_data,

    // display stream out
    output logic  dsp_valid,
    input  logic  dsp_ready,
    output data_t dsp_data
);

    ////////////////////
    // register access

    pia_reg_e reg_sel;
    logic     rd_acc;                           // read accepted this edge
    logic     wr_acc;                           // write accepted this edge

    assign reg_sel = pia_reg_e'(bus.addr[PIA_SEL_W-1:0]);
    assign rd_acc  = bus.sel & ~bus.we;
    assign wr_acc  = bus.sel & bus.we;

    ////////////////////
    // keyboard side

    data_t kbd_q;                               // last character taken
    logic  kbd_pend_q;                          // character waiting for the cpu
    logic  key_take;
    logic  kbd_clear;

    assign key_ready = ~kbd_pend_q;             // one character deep
    assign key_take  = key_valid & key_ready;
    assign kbd_clear = rd_acc & (reg_sel == KBD);

    always_ff @(posedge clk25 or negedge rst_n) begin
        if (!rst_n) begin
            kbd_pend_q <= 1'b0;
        end else if (key_take) begin
            kbd_pend_q <= 1'b1;                 // only possible while nothing pending
        end else if (kbd_clear) begin
            kbd_pend_q <= 1'b0;                 // reading KBD acknowledges the key
        end
    end

    always_ff @(posedge clk25) begin
        if (key_take) begin
            kbd_q <= key_data;
        end
    end

    ////////////////////
    // display side

    data_t dsp_q;                               // character on its way out
    logic  dsp_busy_q;
    logic  dsp_load;

    // a write while busy is dropped, software polls bit 7 first
    assign dsp_load = wr_acc & (reg_sel == DSP) & ~dsp_busy_q;

    always_ff @(posedge clk25 or negedge rst_n) begin
        if (!rst_n) begin
            dsp_busy_q <= 1'b0;
        end else if (dsp_load) begin
            dsp_busy_q <= 1'b1;
        end else if (dsp_ready) begin
            dsp_busy_q <= 1'b0;                 // sink took the character
        end
    end

    always_ff @(posedge clk25) begin
        if (dsp_load) begin
            dsp_q <= bus.wdata;                 // held until the handshake completes
        end
    end

    assign dsp_valid = dsp_busy_q;
    assign dsp_data  = dsp_q;

    ////////////////////
    // read data

    data_t rd_val;
    data_t rdata_q;

    always_comb begin
        rd_val = '0;                            // unused bits and DSPCR read zero
        case (reg_sel)
            KBD: begin
                rd_val             = kbd_q;
                rd_val[STATUS_BIT] = 1'b1;      // apple-1 ascii has bit 7 set
            end
            KBDCR:   rd_val[STATUS_BIT] = kbd_pend_q;
            DSP:     rd_val[STATUS_BIT] = dsp_busy_q;
            default: rd_val = '0;
        endcase
    end

    always_ff @(posedge clk25) begin
        if (rd_acc) begin
            rdata_q <= rd_val;                  // one cycle read latency
        end
    end

    assign bus.rdata = rdata_q;

endmodule

//--- hdl/ram.sv
// synchronous single-port ram slave, one byte wide
`timescale 1ns/1ps

module ram import apple1_map_pkg::*; #(
    parameter int RAM_ADDR_BITS = 13            // 13 bits gives 8 KB
) (
    input  logic clk25,                         // 25 MHz master clock
    mem_bus_if.slave bus
);

    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    data_t mem [DEPTH];                         // contents undefined until written
    data_t rdata_q;

    logic [RAM_ADDR_BITS-1:0] word_addr;        // decoder already checked the upper bits

    assign word_addr = bus.addr[RAM_ADDR_BITS-1:0];

    // read and write share the one port
    always_ff @(posedge clk25) begin
        if (bus.sel) begin
            if (bus.we) begin
                mem[word_addr] <= bus.wdata;    // lands on the accept edge
            end
            rdata_q <= mem[word_addr];          // old contents on a write, unused then
        end
    end

    assign bus.rdata = rdata_q;

endmodule

//--- hdl/bus_decoder.sv
// address decoder with chip selects and the registered read-data return path
`timescale 1ns/1ps

module bus_decoder import apple1_map_pkg::*; #(
    parameter int RAM_ADDR_BITS = 13            // ram depth in address bits
) (
    input  logic    clk25,                      // 25 MHz master clock
    input  logic    rst_n,

    // cpu-side request
    input  logic    req_valid,
    output logic    req_ready,
    input  bus_op_e req_op,
    input  addr_t   req_addr,
    input  data_t   req_wdata,

    // cpu-side response
    output logic    rsp_valid,
    output data_t   rsp_rdata,

    // decoded slaves
    mem_bus_if.master ram_bus,
    mem_bus_if.master pia_bus
);

    ////////////////////
    // address decoding

    localparam addr_t RAM_MASK = addr_t'(RAM_BASE_BITS << RAM_ADDR_BITS);

    logic ready_q;                              // comes up one edge after reset
    logic accept;                               // request taken this edge
    logic is_read;
    logic ram_cs;                               // 0x0000 -> top of ram
    logic pia_cs;                               // 0xD010 -> 0xD013

    assign ram_cs  = (req_addr & RAM_MASK) == '0;
    assign pia_cs  = req_addr[ADDR_W-1:2] == PIA_BASE[ADDR_W-1:2];
    assign accept  = req_valid & ready_q;
    assign is_read = req_op == BUS_READ;

    assign req_ready = ready_q;

    // requests go straight through in the accept cycle
    assign ram_bus.sel   = accept & ram_cs;
    assign ram_bus.we    = req_op == BUS_WRITE;
    assign ram_bus.addr  = req_addr;
    assign ram_bus.wdata = req_wdata;

    assign pia_bus.sel   = accept & pia_cs;
    assign pia_bus.we    = req_op == BUS_WRITE;
    assign pia_bus.addr  = req_addr;
    assign pia_bus.wdata = req_wdata;

    ////////////////////
    // response tracking

    logic rsp_q;                                // read accepted last edge
    logic rd_ram_q;                             // ...and it hit ram
    logic rd_pia_q;                             // ...and it hit the terminal

    always_ff @(posedge clk25 or negedge rst_n) begin
        if (!rst_n) begin
            ready_q  <= 1'b0;
            rsp_q    <= 1'b0;
            rd_ram_q <= 1'b0;
            rd_pia_q <= 1'b0;
        end else begin
            ready_q  <= 1'b1;                   // every slave answers in fixed time
            rsp_q    <= accept & is_read;       // writes get no response
            rd_ram_q <= accept & is_read & ram_cs;
            rd_pia_q <= accept & is_read & pia_cs;
        end
    end

    assign rsp_valid = rsp_q;

    // selected slave to cpu, all ones when nothing was selected
    assign rsp_rdata = rd_ram_q ? ram_bus.rdata :
                       rd_pia_q ? pia_bus.rdata :
                       UNMAPPED_DATA;

endmodule

//--- hdl/mem_bus_if.sv
// one decoded slave port between the bus decoder and a memory-mapped slave
`timescale 1ns/1ps

interface mem_bus_if import apple1_map_pkg::*; ();

    logic  sel;                                 // chip select, one accepted request
    logic  we;                                  // write strobe, valid with sel
    addr_t addr;                                // full bus address
    data_t wdata;                               // write byte
    data_t rdata;                               // read byte, valid one cycle after sel

    // decoder side
    modport master (
        output sel,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    // ram and terminal side
    modport slave (
        input  sel,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

//--- hdl/pia_pkg.sv
// register map of the keyboard/display terminal adapter (apple-1 pia layout)
package pia_pkg;

    ////////////////////
    // register select

    localparam int PIA_SEL_W = 2;               // low address bits into the window

    // same order as the 6821 on the apple-1 board
    typedef enum logic [PIA_SEL_W-1:0] {
        KBD   = 2'd0,                           // keyboard character
        KBDCR = 2'd1,                           // keyboard control, pending flag
        DSP   = 2'd2,                           // display character, busy flag
        DSPCR = 2'd3                            // display control, reads zero
    } pia_reg_e;

    ////////////////////
    // status flags

    // ready/busy flag position in every status read
    // wozmon tests it with BIT/BMI so it has to be the sign bit
    localparam int STATUS_BIT = 7;

endpackage

//--- hdl/apple1_map_pkg.sv
// apple-1 memory map, bus widths and bus opcodes shared by decoder and slaves
package apple1_map_pkg;

    ////////////////////
    // bus widths

    localparam int ADDR_W = 16;                 // 6502 address space
    localparam int DATA_W = 8;                  // one byte per transfer

    typedef logic [ADDR_W-1:0] addr_t;          // one bus address
    typedef logic [DATA_W-1:0] data_t;          // one bus byte

    ////////////////////
    // bus opcodes

    // stands in for the cpu write-enable line
    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    ////////////////////
    // address map

    // upper bits that have to be zero for a ram hit
    // the decoder shifts this mask past the ram depth, so 13 bits gives 0x0000..0x1fff
    localparam addr_t RAM_BASE_BITS = 16'hFFFF;

    // terminal adapter window, four bytes at 0xd010..0xd013
    localparam addr_t PIA_BASE = 16'hD010;

    // floating data bus on the real board reads as all ones
    localparam data_t UNMAPPED_DATA = 8'hFF;

endpackage
